//--- include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Instruction field widths
`define OPCODE_W    6
`define FUNCT_W     6
`define SHAMT_W     5
`define IMM_W       16

// Instruction memory, one word per entry
`define IMEM_DEPTH  256
`define IMEM_ADDR_W 8

`endif

//--- rtl/isa_pkg.sv
`include "mips_defines.svh"

package isa_pkg;

	// Primary opcodes that the core decodes
	typedef enum logic [`OPCODE_W-1:0] {
		OP_RTYPE = 6'b000000,
		OP_ADDI  = 6'b001000, // Same as ADDIU, no traps
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111
	} opcode_e;

	// R-type function codes
	typedef enum logic [`FUNCT_W-1:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// Low IMM_W bits double as the I-type immediate
	typedef struct packed {
		opcode_e                opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`SHAMT_W-1:0]    shamt;
		funct_e                 funct;
	} insn_t;

endpackage

//--- rtl/pipe_pkg.sv
`include "mips_defines.svh"

package pipe_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI // Immediate to upper half
	} alu_op_e;

	// Fetch register, pc is a word index
	typedef struct packed {
		logic                    valid;
		logic [`IMEM_ADDR_W-1:0] pc;
		isa_pkg::insn_t          insn;
	} fetch_t;

	typedef struct packed {
		logic                    valid;
		logic [`IMEM_ADDR_W-1:0] pc;
		alu_op_e                 alu_op;
		logic [`XLEN-1:0]        operand_a;
		logic [`XLEN-1:0]        operand_b;
		logic [`SHAMT_W-1:0]     shamt;
		logic [`REG_ADDR_W-1:0]  dest;
		logic                    wen;
	} decode_t;

	// Writeback, forward and retire all share this view
	typedef struct packed {
		logic                    valid;
		logic [`IMEM_ADDR_W-1:0] pc;
		logic [`REG_ADDR_W-1:0]  dest;
		logic                    wen;
		logic [`XLEN-1:0]        value;
	} result_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

module fetch_stage (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    load_en,
	input  logic [`IMEM_ADDR_W-1:0] load_addr,
	input  logic [`XLEN-1:0]        load_data,
	input  logic                    run,
	output pipe_pkg::fetch_t        fetch
);

	logic [`XLEN-1:0] imem [`IMEM_DEPTH];
	logic [`IMEM_ADDR_W-1:0] pc;

	// Program load port
	always_ff @(posedge clock) begin
		if (load_en)
			imem[load_addr] <= load_data;
	end

	// One word per cycle while run is high, bubbles otherwise
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc    <= '0;
			fetch <= '0;
		end else begin
			fetch.valid <= run;
			fetch.pc    <= pc;
			fetch.insn  <= imem[pc];
			if (run)
				pc <= pc + 1'b1; // Wraps at IMEM_DEPTH
		end
	end

	// Loading the memory under a running core would race the fetch
	a_no_load_while_run: assert property (
		@(posedge clock) disable iff (!rst_n)
		!(load_en && run)
	) else $error("fetch_stage: load_en asserted while run is high");

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

module reg_file (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic [`REG_ADDR_W-1:0] rs_addr,
	input  logic [`REG_ADDR_W-1:0] rt_addr,
	output logic [`XLEN-1:0]       rs_data,
	output logic [`XLEN-1:0]       rt_data,
	input  pipe_pkg::result_t      wb
);

	logic [`XLEN-1:0] regs [1:`NUM_REGS-1]; // r0 is not stored
	logic wr_en;

	assign wr_en = wb.valid && wb.wen && (wb.dest != '0);

	// Write-through so decode sees the value retiring this cycle
	function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (wr_en && (wb.dest == addr))
			return wb.value;
		return regs[addr];
	endfunction

	always_comb begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wb.dest] <= wb.value;
		end
	end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

module decode_stage (
	input  logic                   clock,
	input  logic                   rst_n,
	input  pipe_pkg::fetch_t       fetch,
	output logic [`REG_ADDR_W-1:0] rs_addr,
	output logic [`REG_ADDR_W-1:0] rt_addr,
	input  logic [`XLEN-1:0]       rs_data,
	input  logic [`XLEN-1:0]       rt_data,
	input  pipe_pkg::result_t      ex_fwd,
	output pipe_pkg::decode_t      dec
);

	isa_pkg::insn_t insn;
	pipe_pkg::alu_op_e alu_op;
	logic is_rtype;
	logic use_imm;
	logic sign_ext;
	logic supported;
	logic [`IMM_W-1:0] imm;
	logic [`XLEN-1:0] imm_ext;
	logic [`REG_ADDR_W-1:0] dest;
	logic wen;
	logic [`XLEN-1:0] rs_val;
	logic [`XLEN-1:0] rt_val;

	// Result of the instruction now in execute wins over the register file
	function automatic logic [`XLEN-1:0] fwd_sel(
		input logic [`REG_ADDR_W-1:0] addr,
		input logic [`XLEN-1:0]       rf_data,
		input pipe_pkg::result_t      fwd
	);
		if (fwd.valid && fwd.wen && (fwd.dest != '0) && (fwd.dest == addr))
			return fwd.value;
		return rf_data;
	endfunction

	assign insn    = fetch.insn;
	assign imm     = fetch.insn[`IMM_W-1:0];
	assign rs_addr = insn.rs;
	assign rt_addr = insn.rt;

	always_comb begin
		alu_op    = pipe_pkg::ALU_ADD;
		is_rtype  = 1'b0;
		use_imm   = 1'b1;
		sign_ext  = 1'b0;
		supported = 1'b1;
		case (insn.opcode)
			isa_pkg::OP_RTYPE: begin
				is_rtype = 1'b1;
				use_imm  = 1'b0;
				case (insn.funct)
					isa_pkg::FN_ADD, isa_pkg::FN_ADDU: alu_op = pipe_pkg::ALU_ADD;
					isa_pkg::FN_SUB, isa_pkg::FN_SUBU: alu_op = pipe_pkg::ALU_SUB;
					isa_pkg::FN_AND:  alu_op = pipe_pkg::ALU_AND;
					isa_pkg::FN_OR:   alu_op = pipe_pkg::ALU_OR;
					isa_pkg::FN_XOR:  alu_op = pipe_pkg::ALU_XOR;
					isa_pkg::FN_NOR:  alu_op = pipe_pkg::ALU_NOR;
					isa_pkg::FN_SLT:  alu_op = pipe_pkg::ALU_SLT;
					isa_pkg::FN_SLTU: alu_op = pipe_pkg::ALU_SLTU;
					isa_pkg::FN_SLL:  alu_op = pipe_pkg::ALU_SLL;
					isa_pkg::FN_SRL:  alu_op = pipe_pkg::ALU_SRL;
					isa_pkg::FN_SRA:  alu_op = pipe_pkg::ALU_SRA;
					default:          supported = 1'b0;
				endcase
			end
			isa_pkg::OP_ADDI, isa_pkg::OP_ADDIU: begin
				alu_op   = pipe_pkg::ALU_ADD;
				sign_ext = 1'b1;
			end
			isa_pkg::OP_SLTI: begin
				alu_op   = pipe_pkg::ALU_SLT;
				sign_ext = 1'b1;
			end
			isa_pkg::OP_ORI:  alu_op = pipe_pkg::ALU_OR;
			isa_pkg::OP_XORI: alu_op = pipe_pkg::ALU_XOR;
			isa_pkg::OP_LUI:  alu_op = pipe_pkg::ALU_LUI;
			default:          supported = 1'b0; // Retires as a NOP
		endcase
	end

	assign imm_ext = sign_ext ? {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm}
	                          : {{(`XLEN-`IMM_W){1'b0}}, imm};
	assign dest    = is_rtype ? insn.rd : insn.rt;
	assign wen     = fetch.valid && supported && (dest != '0); // Never write r0

	assign rs_val = fwd_sel(insn.rs, rs_data, ex_fwd);
	assign rt_val = fwd_sel(insn.rt, rt_data, ex_fwd);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dec <= '0;
		end else begin
			dec.valid     <= fetch.valid;
			dec.pc        <= fetch.pc;
			dec.alu_op    <= alu_op;
			dec.operand_a <= rs_val;
			dec.operand_b <= use_imm ? imm_ext : rt_val;
			dec.shamt     <= insn.shamt;
			dec.dest      <= dest;
			dec.wen       <= wen;
		end
	end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

module execute_stage (
	input  logic              clock,
	input  logic              rst_n,
	input  pipe_pkg::decode_t dec,
	output pipe_pkg::result_t ex_fwd,
	output pipe_pkg::result_t result
);

	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] alu_out;
	logic lt_signed;
	logic lt_unsigned;

	assign a = dec.operand_a;
	assign b = dec.operand_b;

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (dec.alu_op)
			pipe_pkg::ALU_ADD:  alu_out = a + b;
			pipe_pkg::ALU_SUB:  alu_out = a - b;
			pipe_pkg::ALU_AND:  alu_out = a & b;
			pipe_pkg::ALU_OR:   alu_out = a | b;
			pipe_pkg::ALU_XOR:  alu_out = a ^ b;
			pipe_pkg::ALU_NOR:  alu_out = ~(a | b);
			pipe_pkg::ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, lt_signed};
			pipe_pkg::ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, lt_unsigned};
			// Shifts act on the rt operand
			pipe_pkg::ALU_SLL:  alu_out = b << dec.shamt;
			pipe_pkg::ALU_SRL:  alu_out = b >> dec.shamt;
			pipe_pkg::ALU_SRA:  alu_out = $signed(b) >>> dec.shamt;
			pipe_pkg::ALU_LUI:  alu_out = {b[`IMM_W-1:0], {(`XLEN-`IMM_W){1'b0}}};
			default:            alu_out = '0;
		endcase
	end

	// Unregistered result, fed back to decode
	always_comb begin
		ex_fwd.valid = dec.valid;
		ex_fwd.pc    = dec.pc;
		ex_fwd.dest  = dec.dest;
		ex_fwd.wen   = dec.wen;
		ex_fwd.value = alu_out;
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			result <= '0;
		else
			result <= ex_fwd;
	end

	// Decode is expected to drop wen for r0 destinations
	a_no_r0_write: assert property (
		@(posedge clock) disable iff (!rst_n)
		(result.valid && result.wen) |-> (result.dest != '0)
	) else $error("execute_stage: write to r0 reached writeback");

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

module mips_core (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    load_en,
	input  logic [`IMEM_ADDR_W-1:0] load_addr,
	input  logic [`XLEN-1:0]        load_data,
	input  logic                    run,
	output pipe_pkg::result_t       retire
);

	pipe_pkg::fetch_t fetch;
	pipe_pkg::decode_t dec;
	pipe_pkg::result_t ex_fwd;
	logic [`REG_ADDR_W-1:0] rs_addr;
	logic [`REG_ADDR_W-1:0] rt_addr;
	logic [`XLEN-1:0] rs_data;
	logic [`XLEN-1:0] rt_data;

	fetch_stage i_fetch (
		.clock     (clock),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.run       (run),
		.fetch     (fetch)
	);

	decode_stage i_decode (
		.clock   (clock),
		.rst_n   (rst_n),
		.fetch   (fetch),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.ex_fwd  (ex_fwd),
		.dec     (dec)
	);

	// Retire doubles as the writeback bus
	reg_file i_reg_file (
		.clock   (clock),
		.rst_n   (rst_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wb      (retire)
	);

	execute_stage i_execute (
		.clock  (clock),
		.rst_n  (rst_n),
		.dec    (dec),
		.ex_fwd (ex_fwd),
		.result (retire)
	);

endmodule

//--- tb/tb_mips_core.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

module tb_mips_core;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 8;
	localparam int PROG_LEN     = 200; // Stays below IMEM_DEPTH, pc never wraps
	localparam logic [31:0] SEED = 32'h344c7090;

	logic clock = 1'b0;
	logic rst_n;
	logic load_en;
	logic [`IMEM_ADDR_W-1:0] load_addr;
	logic [`XLEN-1:0] load_data;
	logic run;
	pipe_pkg::result_t retire;

	logic [31:0] lfsr;
	logic [`XLEN-1:0] prog [PROG_LEN];
	int gap_len [PROG_LEN];
	logic [`XLEN-1:0] model_regs [`NUM_REGS];
	pipe_pkg::result_t exp_q [$];
	int total_gaps;
	int watchdog_cycles;
	logic prog_ready = 1'b0;
	int retired = 0;
	int ctrl_errors = 0;
	int value_errors = 0;
	int extra_errors = 0;

	mips_core i_dut (
		.clock     (clock),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.run       (run),
		.retire    (retire)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {6'b000000, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Only r0..r7, so neighbours depend on each other often
	function automatic logic [31:0] random_insn(input int idx);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [15:0] imm;
		int kind;
		rs    = {2'b00, 3'(take_bits(3))};
		rt    = {2'b00, 3'(take_bits(3))};
		rd    = {2'b00, 3'(take_bits(3))};
		shamt = 5'(take_bits(5));
		imm   = 16'(take_bits(16));
		kind  = int'(take_bits(5) % 19);
		if (idx % 40 == 17) begin
			if ((idx / 40) % 2 == 0)
				return itype_word(6'b100011, rs, rt, imm); // LW opcode
			return rtype_word(6'b011000, rs, rt, rd, shamt); // MULT funct
		end
		case (kind)
			0:  return rtype_word(isa_pkg::FN_ADDU, rs, rt, rd, shamt);
			1:  return rtype_word(isa_pkg::FN_SUBU, rs, rt, rd, shamt);
			2:  return rtype_word(isa_pkg::FN_AND, rs, rt, rd, shamt);
			3:  return rtype_word(isa_pkg::FN_OR, rs, rt, rd, shamt);
			4:  return rtype_word(isa_pkg::FN_XOR, rs, rt, rd, shamt);
			5:  return rtype_word(isa_pkg::FN_NOR, rs, rt, rd, shamt);
			6:  return rtype_word(isa_pkg::FN_SLT, rs, rt, rd, shamt);
			7:  return rtype_word(isa_pkg::FN_SLTU, rs, rt, rd, shamt);
			8:  return rtype_word(isa_pkg::FN_SLL, rs, rt, rd, shamt);
			9:  return rtype_word(isa_pkg::FN_SRL, rs, rt, rd, shamt);
			10: return rtype_word(isa_pkg::FN_SRA, rs, rt, rd, shamt);
			11: return rtype_word(isa_pkg::FN_ADD, rs, rt, rd, shamt);
			12: return rtype_word(isa_pkg::FN_SUB, rs, rt, rd, shamt);
			13: return itype_word(isa_pkg::OP_ADDIU, rs, rt, imm);
			14: return itype_word(isa_pkg::OP_SLTI, rs, rt, imm);
			15: return itype_word(isa_pkg::OP_ORI, rs, rt, imm);
			16: return itype_word(isa_pkg::OP_XORI, rs, rt, imm);
			17: return itype_word(isa_pkg::OP_LUI, rs, rt, imm);
			default: return itype_word(isa_pkg::OP_ADDI, rs, rt, imm);
		endcase
	endfunction

	// Sequential ISA semantics on model_regs, value zeroed when nothing is written
	function automatic pipe_pkg::result_t reference_result(
			input logic [`IMEM_ADDR_W-1:0] pc, input logic [`XLEN-1:0] word);
		pipe_pkg::result_t r;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] zext;
		logic [4:0] shamt;
		logic ok;
		a     = model_regs[word[25:21]];
		b     = model_regs[word[20:16]];
		sext  = {{16{word[15]}}, word[15:0]};
		zext  = {16'h0000, word[15:0]};
		shamt = word[10:6];
		ok    = 1'b1;
		r       = '0;
		r.valid = 1'b1;
		r.pc    = pc;
		if (word[31:26] == 6'h00) begin
			r.dest = word[15:11];
			case (word[5:0])
				6'h20, 6'h21: r.value = a + b;
				6'h22, 6'h23: r.value = a - b;
				6'h24:   r.value = a & b;
				6'h25:   r.value = a | b;
				6'h26:   r.value = a ^ b;
				6'h27:   r.value = ~(a | b);
				6'h2a:   r.value = {31'b0, $signed(a) < $signed(b)};
				6'h2b:   r.value = {31'b0, a < b};
				6'h00:   r.value = b << shamt;
				6'h02:   r.value = b >> shamt;
				6'h03:   r.value = $signed(b) >>> shamt;
				default: ok = 1'b0;
			endcase
		end else begin
			r.dest = word[20:16];
			case (word[31:26])
				6'h08, 6'h09: r.value = a + sext;
				6'h0a:   r.value = {31'b0, $signed(a) < $signed(sext)};
				6'h0d:   r.value = a | zext;
				6'h0e:   r.value = a ^ zext;
				6'h0f:   r.value = {word[15:0], 16'h0000};
				default: ok = 1'b0;
			endcase
		end
		r.wen = ok && (r.dest != '0);
		if (!r.wen)
			r.value = '0;
		return r;
	endfunction

	always @(negedge clock) begin
		pipe_pkg::result_t expected;
		if (rst_n && retire.valid) begin
			if (exp_q.size() == 0) begin
				extra_errors++;
				$display("Retire at %0t with no instruction outstanding, pc %0d", $time, retire.pc);
			end else begin
				expected = exp_q.pop_front();
				retired++;
				if (retire.pc !== expected.pc) begin
					ctrl_errors++;
					$display("[FAIL] %0t: pc got %0d expected %0d", $time, retire.pc, expected.pc);
				end
				if (retire.wen !== expected.wen) begin
					ctrl_errors++;
					$display("[FAIL] %0t: pc %0d wen got %b expected %b", $time, expected.pc,
						retire.wen, expected.wen);
				end
				if (expected.wen && (retire.dest !== expected.dest)) begin
					ctrl_errors++;
					$display("[FAIL] %0t: pc %0d dest got r%0d expected r%0d", $time,
						expected.pc, retire.dest, expected.dest);
				end
				if (expected.wen && (retire.value !== expected.value)) begin
					value_errors++;
					$display("[FAIL] %0t: pc %0d value got %h expected %h", $time,
						expected.pc, retire.value, expected.value);
				end
			end
		end
	end

	initial begin
		wait (prog_ready);
		#(watchdog_cycles * CLK_PERIOD);
		$display("Timeout: the core stopped retiring, %0d of %0d instructions retired",
			retired, PROG_LEN);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		pipe_pkg::result_t exp_r;
		$timeformat(-9, 0, " ns", 0);
		rst_n     = 1'b0;
		load_en   = 1'b0;
		load_addr = '0;
		load_data = '0;
		run       = 1'b0;
		lfsr      = SEED;
		total_gaps = 0;
		for (int r = 0; r < `NUM_REGS; r++)
			model_regs[r] = '0;
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i]    = random_insn(i);
			gap_len[i] = (take_bits(3) == 0) ? int'(take_bits(2)) + 1 : 0;
			total_gaps += gap_len[i];
			exp_r = reference_result(8'(i), prog[i]);
			if (exp_r.wen)
				model_regs[exp_r.dest] = exp_r.value;
			exp_q.push_back(exp_r);
		end
		watchdog_cycles = RESET_CYCLES + 2 * PROG_LEN + total_gaps + 50;
		prog_ready = 1'b1;

		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;

		for (int i = 0; i < PROG_LEN; i++) begin
			@(negedge clock);
			load_en   = 1'b1;
			load_addr = 8'(i);
			load_data = prog[i];
		end
		@(negedge clock);
		load_en = 1'b0;

		// One run-high cycle per instruction, random bubbles in between
		for (int i = 0; i < PROG_LEN; i++) begin
			repeat (gap_len[i]) begin
				@(negedge clock);
				run = 1'b0;
			end
			@(negedge clock);
			run = 1'b1;
		end
		@(negedge clock);
		run = 1'b0;

		wait (retired == PROG_LEN);
		repeat (5) @(negedge clock); // Catch stray retires
		$display("Errors: %0d control, %0d value, %0d unexpected retire; %0d of %0d retired",
			ctrl_errors, value_errors, extra_errors, retired, PROG_LEN);
		if (ctrl_errors + value_errors + extra_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mips_core.sv
tb/tb_mips_core.sv

//--- Makefile
TOP := tb_mips_core

.PHONY: lint sim clean

lint:
	verilator --lint-only -f build.f --top-module mips_core
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
